//--- design/pq_cfg.svh
`ifndef PQ_CFG_SVH
`define PQ_CFG_SVH

// item field widths
`define KEY_W 16        // sort key bits
`define VAL_W 16        // payload bits

// chain geometry
// node depth of at least 2 for the shift walks
`define NODE_DEPTH 4    // slots per node
`define NUM_NODES 3     // nodes in the chain

`endif

//--- design/pq_pkg.sv
`include "pq_cfg.svh"

package pq_pkg;

    // ------------------------------------------------------------
    // item carried on every data path
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`KEY_W-1:0] key;     // sort key
        logic [`VAL_W-1:0] val;     // payload
    } kv_t;

    localparam logic [`KEY_W-1:0] MAX_KEY = '1;                // marks a free slot
    localparam kv_t EMPTY_KV = '{key: MAX_KEY, val: '0};       // what a free slot holds

    // ram write data select
    typedef enum logic [1:0] {
        WS_RAM   = 2'd0,    // shift from the slot being read
        WS_TEMP  = 2'd1,    // drop temp in
        WS_RIGHT = 2'd2,    // refill from right neighbour head
        WS_EMPTY = 2'd3     // free the slot
    } wsel_t;

    // read address offset from wr_addr
    typedef enum logic [1:0] {
        AS_ZERO = 2'd0,
        AS_ONE  = 2'd1,
        AS_TWO  = 2'd2
    } astep_t;

endpackage

//--- design/qq_link_if.sv
`timescale 1ns/10ps

// link between node k (left side) and node k+1 (right side)
interface qq_link_if
    import pq_pkg::*;
();

    logic enq;          // strobes from node k
    logic deq;
    logic repl;
    kv_t  item_lt;      // item going right
    kv_t  item_rt;      // slot 0 of node k+1
    logic rdy;          // node k+1 and beyond idle

    // node k uses this one on its right side
    modport left (
        output enq, deq, repl, item_lt,
        input  item_rt, rdy
    );

    // view from node k+1
    modport right (
        input  enq, deq, repl, item_lt,
        output item_rt, rdy
    );

endinterface

//--- design/qq_fsm.sv
`timescale 1ns/10ps

`include "pq_cfg.svh"

module qq_fsm
    import pq_pkg::*;
#(
    parameter int DEPTH = `NODE_DEPTH,
    localparam int AW = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          enq_i,
    input  logic          deq_i,
    input  logic          repl_i,
    input  logic          t_gt_ram_i,     // temp.key > ram_out.key
    input  logic          t_gt_rt_i,      // temp.key > item_rt.key
    input  logic [AW-1:0] wr_addr_i,
    input  kv_t           ram_out_i,
    output logic          sel_t_o,        // 0 item_i, 1 ram_out
    output logic          ld_t_o,
    output logic          clr_wraddr_o,
    output logic          incr_wraddr_o,
    output logic          we_o,
    output logic          enq_o,
    output logic          deq_o,
    output logic          repl_o,
    output logic          rdy_o,
    output logic          set_full_o,
    output logic          clr_full_o,
    output logic          set_empty_o,
    output logic          clr_empty_o,
    output astep_t        astep_o,
    output wsel_t         wsel_o
);

    typedef enum logic [3:0] {
        INIT1 = 4'd1,   // point at slot 0
        INIT2 = 4'd2,   // fill with empties
        IDLE  = 4'd3,
        ENQ1  = 4'd4,   // insertion walk
        ENQRT = 4'd5,   // overflow to right
        DEQ1  = 4'd6,   // shift-left walk
        DEQRT = 4'd7,   // pull right head into last slot
        REP1  = 4'd8,   // shift-left until temp fits
        REPRT = 4'd9    // last slot vs right head
    } state_t;

    state_t state;
    state_t next;

    logic at_last;      // walking the last slot
    logic at_prev;      // one before the last
    logic ram_free;     // slot being read is empty

    assign at_last  = (wr_addr_i == AW'(DEPTH - 1));
    assign at_prev  = (wr_addr_i == AW'(DEPTH - 2));
    assign ram_free = (ram_out_i.key == MAX_KEY);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INIT1;
        end else begin
            state <= next;
        end
    end

    // ------------------------------------------------------------
    // next state and strobes, all inactive by default
    // ------------------------------------------------------------
    always_comb begin
        rdy_o         = 1'b0;
        sel_t_o       = 1'b0;
        ld_t_o        = 1'b0;
        clr_wraddr_o  = 1'b0;
        incr_wraddr_o = 1'b0;
        we_o          = 1'b0;
        enq_o         = 1'b0;
        deq_o         = 1'b0;
        repl_o        = 1'b0;
        set_full_o    = 1'b0;
        clr_full_o    = 1'b0;
        set_empty_o   = 1'b0;
        clr_empty_o   = 1'b0;
        astep_o       = AS_ZERO;
        wsel_o        = WS_RAM;
        next          = state;

        case (state)
            INIT1: begin
                clr_wraddr_o = 1'b1;
                set_empty_o  = 1'b1;
                clr_full_o   = 1'b1;
                next         = INIT2;
            end

            INIT2: begin
                wsel_o        = WS_EMPTY;       // slot <= MAX_KEY
                we_o          = 1'b1;
                incr_wraddr_o = 1'b1;
                if (at_last) begin
                    clr_wraddr_o = 1'b1;
                    next         = IDLE;
                end
            end

            IDLE: begin
                rdy_o        = 1'b1;
                clr_wraddr_o = 1'b1;
                if (enq_i) begin
                    ld_t_o = 1'b1;              // temp <= new item
                    next   = ENQ1;              // read slot 0 next
                end else if (repl_i) begin
                    ld_t_o  = 1'b1;
                    astep_o = AS_ONE;           // read slot 1, head goes away
                    next    = REP1;
                end else if (deq_i) begin
                    astep_o = AS_ONE;
                    next    = DEQ1;
                end
            end

            ENQ1: begin
                astep_o       = AS_ONE;         // follow wr_addr
                incr_wraddr_o = 1'b1;
                clr_empty_o   = 1'b1;
                if (!t_gt_ram_i) begin
                    // swap temp with this slot, ties stay behind the new item
                    sel_t_o = 1'b1;
                    ld_t_o  = 1'b1;
                    wsel_o  = WS_TEMP;
                    we_o    = 1'b1;
                end
                if (ram_free) begin
                    clr_wraddr_o = 1'b1;
                    if (at_last) begin
                        set_full_o = 1'b1;      // took the last free slot
                    end
                    next = IDLE;
                end else if (at_last) begin
                    next = ENQRT;               // temp now holds the overflow
                end
            end

            ENQRT: begin
                enq_o        = 1'b1;
                clr_wraddr_o = 1'b1;
                next         = IDLE;
            end

            DEQ1: begin
                astep_o       = AS_TWO;         // stay one slot ahead
                incr_wraddr_o = 1'b1;
                wsel_o        = WS_RAM;
                we_o          = 1'b1;
                if (ram_free) begin
                    clr_full_o   = 1'b1;
                    clr_wraddr_o = 1'b1;
                    if (wr_addr_i == '0) begin
                        set_empty_o = 1'b1;     // head was the only item
                    end
                    next = IDLE;
                end else if (at_prev) begin
                    next = DEQRT;
                end
            end

            DEQRT: begin
                wsel_o       = WS_RIGHT;        // pull right head in
                we_o         = 1'b1;
                deq_o        = 1'b1;
                clr_full_o   = 1'b1;            // node decides on item_rt
                clr_wraddr_o = 1'b1;
                next         = IDLE;
            end

            REP1: begin
                astep_o       = AS_TWO;
                incr_wraddr_o = 1'b1;
                clr_empty_o   = 1'b1;
                we_o          = 1'b1;
                if (!t_gt_ram_i) begin
                    wsel_o       = WS_TEMP;     // temp fits here
                    clr_wraddr_o = 1'b1;
                    next         = IDLE;
                end else begin
                    wsel_o = WS_RAM;
                    if (at_prev) begin
                        next = REPRT;
                    end
                end
            end

            REPRT: begin
                clr_wraddr_o = 1'b1;
                we_o         = 1'b1;
                if (t_gt_rt_i) begin
                    wsel_o = WS_RIGHT;          // right head moves in
                    repl_o = 1'b1;              // temp goes on right
                end else begin
                    wsel_o = WS_TEMP;
                end
                next = IDLE;
            end

            default: begin
                next = INIT1;
            end
        endcase
    end

endmodule

//--- design/qq_node.sv
`timescale 1ns/10ps

`include "pq_cfg.svh"

module qq_node
    import pq_pkg::*;
#(
    parameter int DEPTH = `NODE_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     enq_i,
    input  logic     deq_i,
    input  logic     repl_i,
    input  kv_t      item_i,    // from left neighbour or top
    output logic     rdy_o,
    output kv_t      head_o,    // slot 0
    output logic     empty_o,
    output logic     full_o,
    qq_link_if.left  rt         // toward node k+1
);

    localparam int AW = $clog2(DEPTH);
    localparam int RW = AW + 1;          // room for wr_addr + 2

    kv_t ram [DEPTH];

    logic [AW-1:0] wr_addr;
    logic [RW-1:0] rd_addr;
    kv_t           temp;
    kv_t           ram_out;
    kv_t           ram_in;

    logic   sel_t;
    logic   ld_t;
    logic   clr_wraddr;
    logic   incr_wraddr;
    logic   we;
    logic   fsm_rdy;
    logic   set_full;
    logic   clr_full;
    logic   set_empty;
    logic   clr_empty;
    logic   t_gt_ram;
    logic   t_gt_rt;
    logic   rt_keeps_full;
    logic   enq_o_w;
    logic   deq_o_w;
    logic   repl_o_w;
    astep_t astep;
    wsel_t  wsel;

    // ------------------------------------------------------------
    // address counters
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            if (clr_wraddr) begin
                wr_addr <= '0;                  // clear wins over incr
            end else if (incr_wraddr) begin
                wr_addr <= wr_addr + 1'b1;
            end
            rd_addr <= RW'(wr_addr) + RW'(astep);   // slot for next cycle
        end
    end

    // ------------------------------------------------------------
    // ram, combinational read and registered write
    // ------------------------------------------------------------
    assign ram_out = (rd_addr < RW'(DEPTH)) ? ram[rd_addr[AW-1:0]] : EMPTY_KV;
    assign head_o  = ram[0];

    always_comb begin
        case (wsel)
            WS_RAM:   ram_in = ram_out;
            WS_TEMP:  ram_in = temp;
            WS_RIGHT: ram_in = rt.item_rt;
            default:  ram_in = EMPTY_KV;
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ram[wr_addr] <= ram_in;
        end
    end

    // item in flight
    always_ff @(posedge clk) begin
        if (ld_t) begin
            temp <= sel_t ? ram_out : item_i;
        end
    end

    assign t_gt_ram = (temp.key > ram_out.key);
    assign t_gt_rt  = (temp.key > rt.item_rt.key);

    // ------------------------------------------------------------
    // flags
    // ------------------------------------------------------------
    // a refill from a non-empty right node keeps the last slot taken
    assign rt_keeps_full = (wsel == WS_RIGHT) && (rt.item_rt.key != MAX_KEY);

    always_ff @(posedge clk) begin
        if (rst) begin
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else begin
            if (set_full) begin
                full_o <= 1'b1;
            end else if (clr_full) begin
                full_o <= rt_keeps_full;
            end
            if (set_empty) begin
                empty_o <= 1'b1;
            end else if (clr_empty) begin
                empty_o <= 1'b0;
            end
        end
    end

    // busy until everything to the right settles
    assign rdy_o = fsm_rdy & rt.rdy;

    assign rt.enq     = enq_o_w;
    assign rt.deq     = deq_o_w;
    assign rt.repl    = repl_o_w;
    assign rt.item_lt = temp;           // overflow or displaced item sits in temp

    qq_fsm #(
        .DEPTH (DEPTH)
    ) i_fsm (
        .clk           (clk),
        .rst           (rst),
        .enq_i         (enq_i),
        .deq_i         (deq_i),
        .repl_i        (repl_i),
        .t_gt_ram_i    (t_gt_ram),
        .t_gt_rt_i     (t_gt_rt),
        .wr_addr_i     (wr_addr),
        .ram_out_i     (ram_out),
        .sel_t_o       (sel_t),
        .ld_t_o        (ld_t),
        .clr_wraddr_o  (clr_wraddr),
        .incr_wraddr_o (incr_wraddr),
        .we_o          (we),
        .enq_o         (enq_o_w),
        .deq_o         (deq_o_w),
        .repl_o        (repl_o_w),
        .rdy_o         (fsm_rdy),
        .set_full_o    (set_full),
        .clr_full_o    (clr_full),
        .set_empty_o   (set_empty),
        .clr_empty_o   (clr_empty),
        .astep_o       (astep),
        .wsel_o        (wsel)
    );

endmodule

//--- design/quickq.sv
`timescale 1ns/10ps

`include "pq_cfg.svh"

module quickq
    import pq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              enq_i,
    input  logic              deq_i,
    input  logic              repl_i,
    input  logic [`KEY_W-1:0] key_i,
    input  logic [`VAL_W-1:0] val_i,
    output logic              rdy_o,
    output logic              empty_o,
    output logic              full_o,
    output logic [`KEY_W-1:0] head_key_o,
    output logic [`VAL_W-1:0] head_val_o
);

    localparam int N = `NUM_NODES;

    logic [N-1:0] enq_w;
    logic [N-1:0] deq_w;
    logic [N-1:0] repl_w;
    logic [N-1:0] rdy_w;
    logic [N-1:0] empty_w;
    logic [N-1:0] full_w;
    kv_t          item_w [N];
    kv_t          head_w [N];

    qq_link_if lnk [N] ();     // lnk[k] sits right of node k

    // ------------------------------------------------------------
    // node chain
    // ------------------------------------------------------------
    for (genvar k = 0; k < N; k++) begin : g_node
        if (k == 0) begin : g_first
            assign enq_w[0]  = enq_i;          // commands from top ports
            assign deq_w[0]  = deq_i;
            assign repl_w[0] = repl_i;
            assign item_w[0] = '{key: key_i, val: val_i};
        end else begin : g_next
            assign enq_w[k]  = lnk[k-1].enq;
            assign deq_w[k]  = lnk[k-1].deq;
            assign repl_w[k] = lnk[k-1].repl;
            assign item_w[k] = lnk[k-1].item_lt;
            assign lnk[k-1].item_rt = head_w[k];   // head seen by left node
            assign lnk[k-1].rdy     = rdy_w[k];
        end

        qq_node #(.DEPTH(`NODE_DEPTH)) i_node (
            .clk(clk), .rst(rst),
            .enq_i(enq_w[k]), .deq_i(deq_w[k]), .repl_i(repl_w[k]),
            .item_i(item_w[k]), .rdy_o(rdy_w[k]), .head_o(head_w[k]),
            .empty_o(empty_w[k]), .full_o(full_w[k]), .rt(lnk[k])
        );
    end

    // tail looks like an empty idle node, items sent there are lost
    assign lnk[N-1].item_rt = EMPTY_KV;
    assign lnk[N-1].rdy     = 1'b1;

    assign rdy_o      = rdy_w[0];
    assign empty_o    = empty_w[0];        // node 0 empty means all empty
    assign full_o     = full_w[N-1];       // last node full means all full
    assign head_key_o = head_w[0].key;
    assign head_val_o = head_w[0].val;

endmodule

//--- dv/quickq_chk.sv
`timescale 1ns/10ps

`include "pq_cfg.svh"

module quickq_chk
    import pq_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              enq_i,
    input logic              deq_i,
    input logic              repl_i,
    input logic              rdy_i,
    input logic              empty_i,
    input logic              full_i,
    input logic [`KEY_W-1:0] head_key_i
);

    int fail_cnt = 0;   // failed assertion tally

    // strobes only while the chain is idle
    a_cmd_rdy: assert property (@(posedge clk) disable iff (rst)
        (enq_i || deq_i || repl_i) |-> rdy_i)
        else begin
            fail_cnt++;
            $error("command strobe while rdy_o low");
        end

    a_one_cmd: assert property (@(posedge clk) disable iff (rst)
        $onehot0({enq_i, deq_i, repl_i}))
        else begin
            fail_cnt++;
            $error("more than one command strobe high");
        end

    a_flags: assert property (@(posedge clk) disable iff (rst) !(empty_i && full_i))
        else begin
            fail_cnt++;
            $error("empty_o and full_o high together");
        end

    // empty head slot holds the free marker
    a_empty_head: assert property (@(posedge clk) disable iff (rst)
        (empty_i && rdy_i) |-> (head_key_i == MAX_KEY))
        else begin
            fail_cnt++;
            $error("head_key_o is not the free key while empty");
        end

endmodule

//--- dv/quickq_tb.sv
`timescale 1ns/10ps

`include "pq_cfg.svh"

module quickq_tb
    import pq_pkg::*;
();

    localparam int CAP         = `NUM_NODES * `NODE_DEPTH;  // items in the whole chain
    localparam int CLK_NS      = 20;
    localparam int RST_CYCLES  = 16;
    localparam int CMD_CYCLES  = CAP + 4;                   // budget per command
    localparam int RDY_LIMIT   = 4 * CMD_CYCLES;            // one wait on rdy_o
    localparam int N_FILL      = 8;
    localparam int N_PRE       = 5;                         // items before the replaces
    localparam int N_REP       = 16;
    localparam int N_OVER      = 4;                         // enqueues past capacity
    localparam int N_MIX       = 300;
    localparam int N_CMDS      = 2 * N_FILL + (2 * N_PRE + N_REP) + (2 * CAP + N_OVER)
                                 + N_MIX + CAP;
    localparam int WATCHDOG_NS = (N_CMDS * CMD_CYCLES + RST_CYCLES + `NODE_DEPTH + 1) * CLK_NS;

    typedef enum {CMD_ENQ, CMD_DEQ, CMD_REPL} cmd_e;

    logic              clk;
    logic              rst;
    logic              enq;
    logic              deq;
    logic              repl;
    logic [`KEY_W-1:0] key;
    logic [`VAL_W-1:0] val;
    logic              rdy;
    logic              empty;
    logic              full;
    logic [`KEY_W-1:0] head_key;
    logic [`VAL_W-1:0] head_val;

    logic [31:0] lfsr_state;
    kv_t         model_q[$];    // sorted, head first
    int          val_errs   = 0;
    int          other_errs = 0;

    quickq i_dut (
        .clk(clk), .rst(rst), .enq_i(enq), .deq_i(deq), .repl_i(repl),
        .key_i(key), .val_i(val), .rdy_o(rdy), .empty_o(empty), .full_o(full),
        .head_key_o(head_key), .head_val_o(head_val)
    );

    bind quickq quickq_chk i_chk (
        .clk(clk), .rst(rst), .enq_i(enq_i), .deq_i(deq_i), .repl_i(repl_i),
        .rdy_i(rdy_o), .empty_i(empty_o), .full_i(full_o), .head_key_i(head_key_o)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ----------------------------------------------------------
    // random source and reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r          = {r[30:0], lfsr_state[0]};              // one step per bit
        end
        return r;
    endfunction

    function automatic kv_t rand_item(input int key_bits);
        kv_t         it;
        logic [31:0] r;
        r      = rand_bits(key_bits);
        it.key = r[`KEY_W-1:0];
        if (it.key == MAX_KEY) begin
            it.key = MAX_KEY - 1'b1;    // all ones is a free slot
        end
        r      = rand_bits(`VAL_W);
        it.val = r[`VAL_W-1:0];
        return it;
    endfunction

    // new item goes before the first key >= its own
    task automatic model_insert(input kv_t item);
        int idx;
        bit found;
        idx   = model_q.size();
        found = 1'b0;
        foreach (model_q[i]) begin
            if (!found && model_q[i].key >= item.key) begin
                idx   = i;
                found = 1'b1;
            end
        end
        model_q.insert(idx, item);
        if (model_q.size() > CAP) begin
            model_q.delete(CAP);        // largest falls off the tail
        end
    endtask

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_item(input string name, input kv_t exp, input kv_t act);
        if (act !== exp) begin
            val_errs++;
            $display("Fail %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_key(input string name, input logic [`KEY_W-1:0] exp,
                             input logic [`KEY_W-1:0] act);
        if (act !== exp) begin
            val_errs++;
            $display("Fail %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            val_errs++;
            $display("Fail %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_state();
        kv_t head;
        head = '{key: head_key, val: head_val};
        if (model_q.size() == 0) begin
            check_key("head_key_o", MAX_KEY, head_key);
        end else begin
            check_item("head_key_o/head_val_o", model_q[0], head);
        end
        check_flag("empty_o", model_q.size() == 0, empty);
        check_flag("full_o", model_q.size() == CAP, full);
    endtask

    // polled on falling edges, rdy_o settled by then
    task automatic wait_rdy(input string what);
        int cycles;
        cycles = 0;
        while (rdy !== 1'b1 && cycles < RDY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rdy !== 1'b1) begin
            other_errs++;
            $display("rdy_o stayed low for %0d cycles after %s", cycles, what);
        end
    endtask

    // ----------------------------------------------------------
    // command driver and test sequences
    // ----------------------------------------------------------
    task automatic issue(input cmd_e op, input kv_t item);
        kv_t head;
        wait_rdy("the previous command");
        head = '{key: head_key, val: head_val};
        key  = item.key;
        val  = item.val;
        case (op)
            CMD_ENQ: begin
                enq = 1'b1;
                model_insert(item);
            end
            CMD_DEQ: begin
                check_item("head_key_o/head_val_o before dequeue", model_q[0], head);
                deq = 1'b1;
                model_q.delete(0);
            end
            default: begin
                repl = 1'b1;
                model_q.delete(0);      // old head leaves, then the insert
                model_insert(item);
            end
        endcase
        @(negedge clk);                 // one cycle strobe
        enq  = 1'b0;
        deq  = 1'b0;
        repl = 1'b0;
        wait_rdy(op.name());
        check_state();
    endtask

    task automatic drain();
        while (model_q.size() > 0) begin
            issue(CMD_DEQ, '0);
        end
    endtask

    task automatic run_mix();
        logic [31:0] r;
        cmd_e        op;
        for (int n = 0; n < N_MIX; n++) begin
            r = rand_bits(2);
            case (r[1:0])
                2'd1:    op = CMD_DEQ;
                2'd2:    op = CMD_REPL;
                default: op = CMD_ENQ;
            endcase
            if (model_q.size() == 0) begin
                op = CMD_ENQ;           // nothing to take from
            end
            issue(op, rand_item(3));    // keys 0..7, lots of ties
        end
        drain();
    endtask

    task automatic end_run();
        int asrt;
        asrt = i_dut.i_chk.fail_cnt;
        $display("errors: %0d value, %0d other, %0d assertion", val_errs, other_errs, asrt);
        if (val_errs == 0 && other_errs == 0 && asrt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        #(WATCHDOG_NS);
        other_errs++;
        $display("watchdog expired after %0d ns before the tests were done", WATCHDOG_NS);
        end_run();
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        enq        = 1'b0;
        deq        = 1'b0;
        repl       = 1'b0;
        key        = '0;
        val        = '0;
        lfsr_state = 32'h654ae1ad;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        wait_rdy("reset");              // init fill of every node
        check_key("head_key_o", MAX_KEY, head_key);
        check_flag("empty_o", 1'b1, empty);
        check_flag("full_o", 1'b0, full);

        repeat (N_FILL) issue(CMD_ENQ, rand_item(`KEY_W));
        drain();

        repeat (N_PRE) issue(CMD_ENQ, rand_item(`KEY_W));
        repeat (N_REP) issue(CMD_REPL, rand_item(`KEY_W));
        drain();

        repeat (CAP + N_OVER) issue(CMD_ENQ, rand_item(`KEY_W));   // past full
        drain();

        run_mix();
        end_run();
    end

endmodule

//--- src.f
+incdir+design
design/pq_pkg.sv
design/qq_link_if.sv
design/qq_fsm.sv
design/qq_node.sv
design/quickq.sv
dv/quickq_chk.sv
dv/quickq_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the quickq testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module quickq_tb -Mdir "$OBJ" -o quickq_sim -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# let the run continue after an assertion error so the testbench reports it
"./$OBJ/quickq_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
